// File: design/hist_defines.svh
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// histogram geometry
`define HIST_WORDS     64
`define HIST_ADDR_W    6
`define BINS_PER_WORD  4
`define BIN_W          16

// sum of all bins of one histogram
`define TOTAL_W        20

// normalizing product is shifted down by this much
`define NORM_SHIFT     5
`define NORM_W         32
`define DIST_W         64

`endif

// File: design/hist_data_pkg.sv
`default_nettype none
`include "hist_defines.svh"

package hist_data_pkg;

   // one raw bin and the four-bin memory word
   typedef logic [`BIN_W-1:0] bin_t;
   typedef bin_t [`BINS_PER_WORD-1:0] hist_word_t;

   // histogram total, used as the cross scale factor
   typedef logic [`TOTAL_W-1:0] total_t;

   // word address into either histogram memory
   typedef logic [`HIST_ADDR_W-1:0] hist_addr_t;

   // normalized bins, one word's worth
   typedef logic [`NORM_W-1:0] norm_t;
   typedef norm_t [`BINS_PER_WORD-1:0] norm_vec_t;

   // running sum of absolute differences
   typedef logic [`DIST_W-1:0] dist_t;

endpackage

`default_nettype wire

// File: design/hist_ctrl_pkg.sv
`default_nettype none

package hist_ctrl_pkg;

   // read sequencer
   typedef enum logic {FETCH_IDLE, FETCH_READ} fetch_state_t;

   // accumulate sequencer, ACC_DONE drives the done level
   typedef enum logic [1:0] {ACC_IDLE, ACC_RUN, ACC_DONE} acc_state_t;

endpackage

`default_nettype wire

// File: design/hist_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// one memory word pair per valid strobe
interface hist_word_if;
   import hist_data_pkg::*;

   logic       valid;
   hist_word_t cand;
   hist_word_t targ;
   // word from address 0 / from the last address
   logic       first;
   logic       last;

   modport source (output valid, cand, targ, first, last);
   modport sink (input valid, cand, targ, first, last);
endinterface

// cross-normalized bins, no handshake
interface norm_bins_if;
   import hist_data_pkg::*;

   logic      valid;
   norm_vec_t cand_norm;
   norm_vec_t targ_norm;
   logic      first;
   logic      last;

   modport source (output valid, cand_norm, targ_norm, first, last);
   modport sink (input valid, cand_norm, targ_norm, first, last);
endinterface

`default_nettype wire

// File: design/bin_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "hist_defines.svh"

module bin_fetch (
   input  wire                             clk,
   input  wire                             reset,
   input  wire                             start,
   input  wire hist_data_pkg::hist_word_t  cand_data,
   input  wire hist_data_pkg::hist_word_t  targ_data,
   output hist_data_pkg::hist_addr_t       hist_addr,
   output logic                            read_en,
   hist_word_if.source                     words
);
   import hist_ctrl_pkg::*;
   import hist_data_pkg::*;

   localparam hist_addr_t LAST_ADDR = hist_addr_t'(`HIST_WORDS - 1);

   fetch_state_t state;
   // strobe and flags lined up with the memory output
   logic rd_valid;
   logic rd_first;
   logic rd_last;

   // one read per cycle, start only taken when idle
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state     <= FETCH_IDLE;
         read_en   <= 1'b0;
         hist_addr <= '0;
      end
      else
      begin
         case (state)
            FETCH_IDLE:
            begin
               if (start)
               begin
                  state     <= FETCH_READ;
                  read_en   <= 1'b1;
                  hist_addr <= '0;
               end
            end
            FETCH_READ:
            begin
               // last address issued, drop the strobe
               if (hist_addr == LAST_ADDR)
               begin
                  state   <= FETCH_IDLE;
                  read_en <= 1'b0;
               end
               else
                  hist_addr <= hist_addr + 1'b1;
            end
         endcase
      end
   end

   // memory answers one cycle after the strobe
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rd_valid    <= 1'b0;
         rd_first    <= 1'b0;
         rd_last     <= 1'b0;
         words.valid <= 1'b0;
         words.first <= 1'b0;
         words.last  <= 1'b0;
      end
      else
      begin
         rd_valid    <= read_en;
         rd_first    <= read_en && (hist_addr == '0);
         rd_last     <= read_en && (hist_addr == LAST_ADDR);
         words.valid <= rd_valid;
         words.first <= rd_first;
         words.last  <= rd_last;
      end
   end

   // capture both words together
   always_ff @(posedge clk)
   begin
      if (rd_valid)
      begin
         words.cand <= cand_data;
         words.targ <= targ_data;
      end
   end

   a_idle_no_read: assert property (@(posedge clk) disable iff (reset)
      (state == FETCH_IDLE) |-> !read_en);

endmodule

`default_nettype wire

// File: design/bin_normalizer.sv
`timescale 1ns/1ps
`default_nettype none
`include "hist_defines.svh"

module bin_normalizer (
   input  wire                          clk,
   input  wire                          reset,
   input  wire hist_data_pkg::total_t   total_cand,
   input  wire hist_data_pkg::total_t   total_targ,
   hist_word_if.sink                    words,
   norm_bins_if.source                  norms
);
   import hist_data_pkg::*;

   localparam int PROD_W = `BIN_W + `TOTAL_W;

   // bin times the other histogram's total, scaled down
   function automatic norm_t scale(input bin_t bin, input total_t total);
      logic [PROD_W-1:0] prod;
      prod = PROD_W'(bin) * PROD_W'(total);
      return norm_t'(prod >> `NORM_SHIFT);
   endfunction

   norm_vec_t cand_scaled;
   norm_vec_t targ_scaled;

   // eight multipliers, two per lane
   always_comb
   begin
      for (int i = 0; i < `BINS_PER_WORD; i++)
      begin
         cand_scaled[i] = scale(words.cand[i], total_targ);
         targ_scaled[i] = scale(words.targ[i], total_cand);
      end
   end

   // single stage, flags travel with the products
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         norms.valid <= 1'b0;
         norms.first <= 1'b0;
         norms.last  <= 1'b0;
      end
      else
      begin
         norms.valid <= words.valid;
         norms.first <= words.first;
         norms.last  <= words.last;
      end
   end

   always_ff @(posedge clk)
   begin
      if (words.valid)
      begin
         norms.cand_norm <= cand_scaled;
         norms.targ_norm <= targ_scaled;
      end
   end

   // 36-bit product minus the shift leaves 31 bits
   for (genvar g = 0; g < `BINS_PER_WORD; g++)
   begin : g_range_chk
      a_norm_range: assert property (@(posedge clk) disable iff (reset)
         words.valid |=> !norms.cand_norm[g][`NORM_W-1] && !norms.targ_norm[g][`NORM_W-1]);
   end

endmodule

`default_nettype wire

// File: design/distance_accumulator.sv
`timescale 1ns/1ps
`default_nettype none
`include "hist_defines.svh"

module distance_accumulator (
   input  wire                    clk,
   input  wire                    reset,
   norm_bins_if.sink              norms,
   output hist_data_pkg::dist_t   distance,
   output logic                   done
);
   import hist_ctrl_pkg::*;
   import hist_data_pkg::*;

   // four 32-bit terms need two more bits
   localparam int SUM_W = `NORM_W + 2;

   acc_state_t state;
   norm_vec_t abs_diff;
   logic s1_valid;
   logic s1_first;
   logic s1_last;
   logic [SUM_W-1:0] diff_sum;

   // stage 1 flags
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         s1_first <= 1'b0;
         s1_last  <= 1'b0;
      end
      else
      begin
         s1_valid <= norms.valid;
         s1_first <= norms.first;
         s1_last  <= norms.last;
      end
   end

   // stage 1 absolute differences, both operands unsigned
   always_ff @(posedge clk)
   begin
      if (norms.valid)
      begin
         for (int i = 0; i < `BINS_PER_WORD; i++)
         begin
            abs_diff[i] <= (norms.cand_norm[i] >= norms.targ_norm[i]) ?
                           norms.cand_norm[i] - norms.targ_norm[i] :
                           norms.targ_norm[i] - norms.cand_norm[i];
         end
      end
   end

   always_comb
   begin
      diff_sum = '0;
      for (int i = 0; i < `BINS_PER_WORD; i++)
      begin
         diff_sum = diff_sum + SUM_W'(abs_diff[i]);
      end
   end

   // stage 2, load on first word, add on the rest
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state    <= ACC_IDLE;
         distance <= '0;
      end
      else
      begin
         case (state)
            ACC_IDLE, ACC_DONE:
            begin
               // result holds until a new run starts
               if (s1_valid && s1_first)
               begin
                  distance <= dist_t'(diff_sum);
                  state    <= s1_last ? ACC_DONE : ACC_RUN;
               end
            end
            ACC_RUN:
            begin
               if (s1_valid)
               begin
                  distance <= distance + dist_t'(diff_sum);
                  if (s1_last)
                     state <= ACC_DONE;
               end
            end
            default:
               state <= ACC_IDLE;
         endcase
      end
   end

   assign done = (state == ACC_DONE);

   // after a result only a new run's first word may arrive
   a_done_first: assert property (@(posedge clk) disable iff (reset)
      (state == ACC_DONE && s1_valid) |-> s1_first);

endmodule

`default_nettype wire

// File: design/hist_distance_top.sv
`timescale 1ns/1ps
`default_nettype none

module hist_distance_top (
   input  wire                             clk,
   input  wire                             reset,
   input  wire                             start,
   // synchronous histogram memories
   input  wire hist_data_pkg::hist_word_t  cand_data,
   input  wire hist_data_pkg::hist_word_t  targ_data,
   input  wire hist_data_pkg::total_t      total_cand,
   input  wire hist_data_pkg::total_t      total_targ,
   output wire hist_data_pkg::hist_addr_t  hist_addr,
   output wire                             read_en,
   output wire hist_data_pkg::dist_t       distance,
   output wire                             done
);

   // fetch to normalizer
   hist_word_if words_if ();
   // normalizer to accumulator
   norm_bins_if norms_if ();

   bin_fetch fetch_i (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .cand_data (cand_data),
      .targ_data (targ_data),
      .hist_addr (hist_addr),
      .read_en   (read_en),
      .words     (words_if.source)
   );

   // cross normalization, candidate by target total and back
   bin_normalizer norm_i (
      .clk        (clk),
      .reset      (reset),
      .total_cand (total_cand),
      .total_targ (total_targ),
      .words      (words_if.sink),
      .norms      (norms_if.source)
   );

   distance_accumulator acc_i (
      .clk      (clk),
      .reset    (reset),
      .norms    (norms_if.sink),
      .distance (distance),
      .done     (done)
   );

endmodule

`default_nettype wire

// File: dv/hist_distance_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "hist_defines.svh"

module hist_distance_tb;
   import hist_data_pkg::*;

   localparam int TIMEOUT = 4 * `HIST_WORDS + 50;

   logic clk;
   logic reset;
   logic start;
   hist_word_t cand_data;
   hist_word_t targ_data;
   total_t total_cand;
   total_t total_targ;
   hist_addr_t hist_addr;
   logic read_en;
   dist_t distance;
   logic done;

   // behavioural histogram memories
   hist_word_t cand_mem [`HIST_WORDS];
   hist_word_t targ_mem [`HIST_WORDS];

   // read monitor state
   int reads_total = 0;
   int burst_len = 0;
   logic prev_read_en = 1'b0;

   hist_distance_top dut_i (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .cand_data  (cand_data),
      .targ_data  (targ_data),
      .total_cand (total_cand),
      .total_targ (total_targ),
      .hist_addr  (hist_addr),
      .read_en    (read_en),
      .distance   (distance),
      .done       (done)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s at %0t", why, $time);
      $display("=== FAIL ===");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("mismatch at %0t: %s got %0h expected %0h", $time, what, actual, expected);
         $display("=== FAIL ===");
         $fatal(1, "stopping at first error");
      end
   endtask

   // one cycle, then settle past the edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic wait_for_done(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (done !== level)
      begin
         if (cycles >= TIMEOUT)
            stop_run({"timeout while waiting for ", what});
         step();
         cycles++;
      end
   endtask

   // synchronous read, data a short delay after the edge
   always @(posedge clk)
   begin
      hist_addr_t addr_q;
      if (read_en)
      begin
         addr_q = hist_addr;
         // bursts start at 0 and climb by one
         check_value(64'(addr_q), prev_read_en ? 64'(burst_len) : 64'd0, "read address");
         burst_len = prev_read_en ? burst_len + 1 : 1;
         reads_total++;
      end
      else if (prev_read_en)
         check_value(64'(burst_len), 64'(`HIST_WORDS), "read burst length");
      prev_read_en = read_en;
      if (read_en)
      begin
         #1;
         cand_data = cand_mem[addr_q];
         targ_data = targ_mem[addr_q];
      end
   end

   // constant fill for F, random bins otherwise
   task automatic fill_memories(input logic [7:0] kind, input bin_t cf, input bin_t tf);
      for (int a = 0; a < `HIST_WORDS; a++)
      begin
         for (int b = 0; b < `BINS_PER_WORD; b++)
         begin
            cand_mem[a][b] = (kind == "F") ? cf : bin_t'($urandom());
            targ_mem[a][b] = (kind == "F") ? tf : bin_t'($urandom());
         end
      end
   endtask

   // sum of |cand*tt >> 5 - targ*tc >> 5| over every bin
   function automatic dist_t ref_distance(input total_t tc, input total_t tt);
      dist_t sum;
      logic [63:0] c;
      logic [63:0] t;
      sum = '0;
      for (int a = 0; a < `HIST_WORDS; a++)
      begin
         for (int b = 0; b < `BINS_PER_WORD; b++)
         begin
            c = (64'(cand_mem[a][b]) * 64'(tt)) >> `NORM_SHIFT;
            t = (64'(targ_mem[a][b]) * 64'(tc)) >> `NORM_SHIFT;
            sum = sum + ((c >= t) ? c - t : t - c);
         end
      end
      return sum;
   endfunction

   task automatic run_one(input logic [7:0] kind, input total_t tc, input total_t tt,
                          input bin_t cf, input bin_t tf, input dist_t exp_file);
      dist_t expected;
      int reads_before;
      fill_memories(kind, cf, tf);
      expected = (kind == "F") ? exp_file : ref_distance(tc, tt);
      reads_before = reads_total;
      total_cand = tc;
      total_targ = tt;
      start = 1'b1;
      step();
      start = 1'b0;
      // previous result must clear before the new one
      wait_for_done(1'b0, "done to fall at the start of a run");
      // start while busy, must not add reads
      step();
      start = 1'b1;
      step();
      start = 1'b0;
      wait_for_done(1'b1, "done to rise at the end of a run");
      check_value(64'(reads_total - reads_before), 64'(`HIST_WORDS), "reads per run");
      check_value(distance, expected, "distance");
      // result holds while done is high
      repeat (3) step();
      check_value(64'(done), 64'd1, "done level after result");
      check_value(distance, expected, "held distance");
   endtask

   initial
   begin
      int fd;
      int n;
      int tests_run;
      string line;
      logic [7:0] kind;
      total_t tc;
      total_t tt;
      bin_t cf;
      bin_t tf;
      dist_t exp_file;
      void'($urandom(32'haf4395a9));
      reset = 1'b1;
      start = 1'b0;
      cand_data = '0;
      targ_data = '0;
      total_cand = '0;
      total_targ = '0;
      tests_run = 0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      step();
      // idle outputs after reset
      check_value(64'(read_en), 64'd0, "read_en after reset");
      check_value(64'(done), 64'd0, "done after reset");
      check_value(distance, 64'd0, "distance after reset");
      fd = $fopen("dv/hist_patterns.txt", "r");
      if (fd == 0)
         stop_run("could not open the pattern file dv/hist_patterns.txt");
      while (!$feof(fd))
      begin
         if ($fgets(line, fd) == 0)
            break;
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%c %h %h %h %h %h", kind, tc, tt, cf, tf, exp_file);
         if (n != 6 || (kind != "F" && kind != "R"))
            stop_run({"malformed pattern line: ", line});
         // runs go back to back, no idle gap
         run_one(kind, tc, tt, cf, tf, exp_file);
         tests_run++;
      end
      $fclose(fd);
      if (tests_run == 0)
         stop_run("the pattern file held no tests");
      else
      begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/hist_data_pkg.sv
design/hist_ctrl_pkg.sv
design/hist_ifs.sv
design/bin_fetch.sv
design/bin_normalizer.sv
design/distance_accumulator.sv
design/hist_distance_top.sv
dv/hist_distance_tb.sv

// File: Makefile
# Verilator build and run of the histogram distance testbench

VERILATOR ?= verilator
TOP       ?= hist_distance_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/hist_patterns.txt
# kind total_cand total_targ cand_fill targ_fill expected_distance (all hex)
# kind F fills every bin with the fills, kind R uses random bins and ignores the last three
F 00100 00100 0010 0010 0000000000
F 00100 00200 0020 0020 0000010000
F 40000 00003 0007 0001 0000200000
F fffff fffff ffff 0001 7ffef80100
F 01234 00567 0300 0100 00000ff800
R 80000 7ffff 0000 0000 0000000000
R fffff 00001 0000 0000 0000000000
R 12345 6789a 0000 0000 0000000000
F 00100 00100 abcd abcd 0000000000
